// File: vlog.f
+incdir+hdl
hdl/lc4_pkg.sv
hdl/lc4_fetch.sv
hdl/lc4_decode.sv
hdl/lc4_regfile.sv
hdl/lc4_execute.sv
hdl/lc4_superscalar.sv
bench/tb_clock.sv
bench/tb_lc4.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc4
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= SOME TESTS FAILED

SOURCES := $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_lc4.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module tb_lc4 import lc4_pkg::*; ();

   localparam int NUM_INSN   = 64;
   localparam int MEM_DEPTH  = 256;
   localparam int MAX_CYCLES = NUM_INSN * 2 + 20;
   localparam int LATENCY    = 3; // fetch to writeback

   logic   gwe;
   logic   i_reset;
   word_t  insn_a;
   word_t  insn_b;
   word_t  cur_pc;
   trace_t trace_a;
   trace_t trace_b;

   word_t  imem [MEM_DEPTH];       // program at LC4_RESET_PC with NOPs behind it
   word_t  arch_regs [`LC4_NUM_REGS];
   trace_t exp_tr [NUM_INSN];
   int     exp_pair [NUM_INSN];    // issue cycle of each instruction
   int     exp_splits;

   int     cyc;
   int     retired;
   int     pipes_seen;
   int     mismatches;
   int     failures;
   logic   held_valid;             // last cycle had B split off
   word_t  held_pc;

   tb_clock u_clock (
      .o_gwe   (gwe),
      .o_reset (i_reset)
   );

   lc4_superscalar uut (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_insn_a  (insn_a),
      .i_insn_b  (insn_b),
      .o_cur_pc  (cur_pc),
      .o_trace_a (trace_a),
      .o_trace_b (trace_b)
   );

   function automatic logic [31:0] lcg_next(logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // top three bits pick one of the eight kept instructions
   function automatic word_t random_insn(logic [31:0] r);
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      rd = r[28:26];
      rs = r[25:23];
      rt = r[22:20];
      case (r[31:29])
         3'd0:    return {4'b0001, rd, rs, 3'b000, rt}; // ADD
         3'd1:    return {4'b0001, rd, rs, 3'b010, rt}; // SUB
         3'd2:    return {4'b0001, rd, rs, 1'b1, r[15:11]}; // ADDI
         3'd3:    return {4'b0101, rd, rs, 3'b000, rt}; // AND
         3'd4:    return {4'b0101, rd, rs, 3'b001, 3'b000}; // NOT
         3'd5:    return {4'b0101, rd, rs, 3'b010, rt}; // OR
         3'd6:    return {4'b0101, rd, rs, 3'b011, rt}; // XOR
         default: return {4'b1001, rd, r[19:11]}; // CONST
      endcase
   endfunction

   function automatic logic reads_reg(word_t insn, logic [2:0] sel);
      if (insn[15:12] == 4'b1001) begin
         return 1'b0;
      end
      if ((insn[15:12] == 4'b0001 && insn[5]) ||
          (insn[15:12] == 4'b0101 && insn[5:3] == 3'b001)) begin
         return insn[8:6] == sel; // ADDI and NOT use rs only
      end
      return insn[8:6] == sel || insn[2:0] == sel;
   endfunction

   // runs one instruction on the architectural model in program order
   function automatic trace_t ref_exec(word_t pc, word_t insn);
      trace_t t;
      word_t  rs;
      word_t  rt;
      word_t  res;
      rs = arch_regs[insn[8:6]];
      rt = arch_regs[insn[2:0]];
      case (insn[15:12])
         4'b0001: begin
            if (insn[5]) begin
               res = rs + {{11{insn[4]}}, insn[4:0]}; // ADDI
            end else if (insn[4]) begin
               res = rs - rt;
            end else begin
               res = rs + rt;
            end
         end
         4'b0101: begin
            case (insn[4:3])
               2'b00:   res = rs & rt;
               2'b01:   res = ~rs;
               2'b10:   res = rs | rt;
               default: res = rs ^ rt;
            endcase
         end
         default: res = {{7{insn[8]}}, insn[8:0]}; // CONST with imm9 sign extended
      endcase
      t            = '0;
      t.pc         = pc;
      t.insn       = insn;
      t.stall      = STALL_NONE;
      t.regfile_we = 1'b1;
      t.wsel       = insn[11:9];
      t.rd_data    = res;
      t.nzp_we     = 1'b1;
      t.nzp_bits   = res[15] ? 3'b100 : ((res == 16'h0) ? 3'b010 : 3'b001);
      return t;
   endfunction

   function automatic word_t imem_read(word_t addr);
      word_t offset;
      if ($isunknown(addr)) begin
         return '0;
      end
      offset = addr - word_t'(`LC4_RESET_PC);
      if (offset < word_t'(MEM_DEPTH)) begin
         return imem[offset[7:0]];
      end
      return '0;
   endfunction

   assign insn_a = imem_read(cur_pc);
   assign insn_b = imem_read(cur_pc + word_t'(1));

   task automatic compare_value(string name, logic [15:0] got, logic [15:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(string msg);
      failures++;
      $display("error at %0t: %s", $time, msg);
   endtask

   task automatic check_empty(string slot, trace_t t);
      compare_value({slot, ".stall"}, 16'(t.stall), 16'(STALL_EMPTY));
      compare_value({slot, ".regfile_we"}, 16'(t.regfile_we), 16'd0);
      compare_value({slot, ".nzp_we"}, 16'(t.nzp_we), 16'd0);
   endtask

   task automatic retire_slot(string slot, trace_t t);
      trace_t e;
      case (t.stall)
         STALL_EMPTY: begin // reset bubble or NOP
            compare_value({slot, ".regfile_we"}, 16'(t.regfile_we), 16'd0);
            compare_value({slot, ".nzp_we"}, 16'(t.nzp_we), 16'd0);
         end
         STALL_PIPE: begin
            pipes_seen++;
            if (slot != "trace_b") begin
               report_failure("slot A carries a pipe stall");
            end
            compare_value({slot, ".regfile_we"}, 16'(t.regfile_we), 16'd0);
            compare_value({slot, ".nzp_we"}, 16'(t.nzp_we), 16'd0);
            if (retired < NUM_INSN) begin
               compare_value({slot, ".pc (split)"}, t.pc, exp_tr[retired].pc);
            end
            held_valid = 1'b1;
            held_pc    = t.pc;
         end
         STALL_NONE: begin
            if (retired >= NUM_INSN) begin
               report_failure($sformatf("%s retired an instruction past the program", slot));
            end else begin
               e = exp_tr[retired];
               compare_value({slot, ".pc"}, t.pc, e.pc);
               compare_value({slot, ".insn"}, t.insn, e.insn);
               compare_value({slot, ".regfile_we"}, 16'(t.regfile_we), 16'(e.regfile_we));
               compare_value({slot, ".wsel"}, 16'(t.wsel), 16'(e.wsel));
               compare_value({slot, ".rd_data"}, t.rd_data, e.rd_data);
               compare_value({slot, ".nzp_we"}, 16'(t.nzp_we), 16'(e.nzp_we));
               compare_value({slot, ".nzp_bits"}, 16'(t.nzp_bits), 16'(e.nzp_bits));
               compare_value({slot, " retire cycle"}, 16'(cyc), 16'(exp_pair[retired] + LATENCY));
               retired++;
            end
         end
         default: report_failure($sformatf("%s has an unknown stall code", slot));
      endcase
   endtask

   task automatic check_cycle();
      if (cyc < LATENCY) begin
         if (cyc == 0) begin
            compare_value("o_cur_pc", cur_pc, `LC4_RESET_PC);
         end
         check_empty("trace_a", trace_a);
         check_empty("trace_b", trace_b);
      end else begin
         if (held_valid) begin
            compare_value("trace_a.pc (held)", trace_a.pc, held_pc);
            compare_value("trace_a.stall (held)", 16'(trace_a.stall), 16'(STALL_NONE));
            held_valid = 1'b0;
         end
         retire_slot("trace_a", trace_a);
         retire_slot("trace_b", trace_b);
         if (trace_a.stall == STALL_NONE && trace_b.stall == STALL_NONE) begin
            compare_value("pc step a to b", trace_b.pc - trace_a.pc, 16'd1);
         end
      end
   endtask

   initial begin : run_test
      logic [31:0] seed;
      int          i;
      int          pair;
      seed       = 32'hd712_c3e2;
      cyc        = 0;
      retired    = 0;
      pipes_seen = 0;
      mismatches = 0;
      failures   = 0;
      held_valid = 1'b0;
      held_pc    = '0;
      for (int k = 0; k < MEM_DEPTH; k++) begin
         imem[k] = '0;
      end
      for (int k = 0; k < NUM_INSN; k++) begin
         seed    = lcg_next(seed);
         imem[k] = random_insn(seed);
      end
      for (int k = 0; k < `LC4_NUM_REGS; k++) begin
         arch_regs[k] = '0;
      end
      for (int k = 0; k < NUM_INSN; k++) begin
         exp_tr[k] = ref_exec(word_t'(`LC4_RESET_PC + k), imem[k]);
         arch_regs[imem[k][11:9]] = exp_tr[k].rd_data;
      end

      // pairs issue together unless B reads what A writes
      i          = 0;
      pair       = 0;
      exp_splits = 0;
      while (i < NUM_INSN) begin
         exp_pair[i] = pair;
         if (i + 1 < NUM_INSN && reads_reg(imem[i + 1], imem[i][11:9])) begin
            exp_splits++;
            i = i + 1;
         end else begin
            if (i + 1 < NUM_INSN) begin
               exp_pair[i + 1] = pair;
            end
            i = i + 2;
         end
         pair++;
      end

      @(negedge i_reset);
      while (retired < NUM_INSN && cyc < MAX_CYCLES) begin
         @(negedge gwe); // traces settle after the rising edge
         check_cycle();
         cyc++;
      end
      if (retired < NUM_INSN) begin
         report_failure($sformatf("timeout after %0d cycles with %0d of %0d instructions retired",
                                  cyc, retired, NUM_INSN));
      end
      compare_value("split count", 16'(pipes_seen), 16'(exp_splits));

      $display("mismatches %0d, other errors %0d, retired %0d of %0d, splits %0d",
               mismatches, failures, retired, NUM_INSN, pipes_seen);
      if (mismatches == 0 && failures == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int RESET_CYCLES = 3
) (
   output logic o_gwe,
   output logic o_reset
);

   initial begin
      o_gwe = 1'b0;
      forever #2 o_gwe = ~o_gwe; // 4 ns period
   end

   // release lands just after a rising edge
   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_gwe);
      #1 o_reset = 1'b0;
   end

endmodule

// File: hdl/lc4_superscalar.sv
`timescale 1ns/1ps

module lc4_superscalar import lc4_pkg::*; (
   input  logic   gwe,
   input  logic   i_reset,
   input  word_t  i_insn_a,  // imem word at o_cur_pc
   input  word_t  i_insn_b,  // imem word at o_cur_pc+1
   output word_t  o_cur_pc,
   output trace_t o_trace_a, // writeback stage, slot A
   output trace_t o_trace_b
);

   localparam trace_t TRACE_EMPTY = '{pc: '0, insn: '0, stall: STALL_EMPTY,
                                      regfile_we: 1'b0, wsel: '0, rd_data: '0,
                                      nzp_we: 1'b0, nzp_bits: '0};

   // decode stage
   slot_t  slot_a;
   slot_t  slot_b;
   dec_t   dec_a;
   dec_t   dec_b;
   word_t  rs_data_a;
   word_t  rt_data_a;
   word_t  rs_data_b;
   word_t  rt_data_b;
   logic   split;

   // execute stage
   slot_t  ex_slot_a;
   slot_t  ex_slot_b;
   dec_t   ex_dec_a;
   dec_t   ex_dec_b;
   word_t  ex_rs_a;
   word_t  ex_rt_a;
   word_t  ex_rs_b;
   word_t  ex_rt_b;
   word_t  result_a;
   word_t  result_b;
   nzp_t   nzp_a;
   nzp_t   nzp_b;

   // writeback stage
   trace_t wb_a;
   trace_t wb_b;

   function automatic trace_t make_trace(slot_t s, dec_t d, word_t result, nzp_t nzp);
      trace_t t;
      t.pc         = s.pc;
      t.insn       = s.insn;
      t.stall      = s.stall;
      t.regfile_we = d.regfile_we;
      t.wsel       = d.wsel;
      t.rd_data    = result;
      t.nzp_we     = d.regfile_we; // every kept writer also sets nzp
      t.nzp_bits   = nzp;
      return t;
   endfunction

   lc4_fetch u_fetch (
      .gwe      (gwe),
      .i_reset  (i_reset),
      .i_split  (split),
      .i_insn_a (i_insn_a),
      .i_insn_b (i_insn_b),
      .o_cur_pc (o_cur_pc),
      .o_slot_a (slot_a),
      .o_slot_b (slot_b)
   );

   lc4_decode u_decode_a (.i_insn(slot_a.insn), .o_dec(dec_a));
   lc4_decode u_decode_b (.i_insn(slot_b.insn), .o_dec(dec_b));

   // B cannot issue beside the A that produces its operand
   assign split = dec_a.regfile_we &&
                  ((dec_b.r1re && dec_b.r1sel == dec_a.wsel) ||
                   (dec_b.r2re && dec_b.r2sel == dec_a.wsel));

   lc4_regfile u_regfile (
      .gwe         (gwe),
      .i_reset     (i_reset),
      .i_rs_a      (dec_a.r1sel),
      .i_rt_a      (dec_a.r2sel),
      .i_rs_b      (dec_b.r1sel),
      .i_rt_b      (dec_b.r2sel),
      .o_rs_data_a (rs_data_a),
      .o_rt_data_a (rt_data_a),
      .o_rs_data_b (rs_data_b),
      .o_rt_data_b (rt_data_b),
      .i_wb_a      (wb_a),
      .i_wb_b      (wb_b)
   );

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         ex_slot_a <= SLOT_EMPTY;
         ex_slot_b <= SLOT_EMPTY;
         ex_dec_a  <= '0;
         ex_dec_b  <= '0;
         wb_a      <= TRACE_EMPTY;
         wb_b      <= TRACE_EMPTY;
      end else begin
         ex_slot_a <= slot_a;
         ex_dec_a  <= dec_a;
         if (split) begin
            // B comes back from fetch as the next A and leaves only its pc and insn here
            ex_slot_b <= '{pc: slot_b.pc, insn: slot_b.insn, stall: STALL_PIPE};
            ex_dec_b  <= '0;
         end else begin
            ex_slot_b <= slot_b;
            ex_dec_b  <= dec_b;
         end
         wb_a <= make_trace(ex_slot_a, ex_dec_a, result_a, nzp_a);
         wb_b <= make_trace(ex_slot_b, ex_dec_b, result_b, nzp_b);
      end
   end

   always_ff @(posedge gwe) begin
      ex_rs_a <= rs_data_a;
      ex_rt_a <= rt_data_a;
      ex_rs_b <= rs_data_b;
      ex_rt_b <= rt_data_b;
   end

   lc4_execute u_execute_a (
      .i_dec     (ex_dec_a),
      .i_rs_data (ex_rs_a),
      .i_rt_data (ex_rt_a),
      .i_wb_a    (wb_a),
      .i_wb_b    (wb_b),
      .o_result  (result_a),
      .o_nzp     (nzp_a)
   );

   lc4_execute u_execute_b (
      .i_dec     (ex_dec_b),
      .i_rs_data (ex_rs_b),
      .i_rt_data (ex_rt_b),
      .i_wb_a    (wb_a),
      .i_wb_b    (wb_b),
      .o_result  (result_b),
      .o_nzp     (nzp_b)
   );

   assign o_trace_a = wb_a;
   assign o_trace_b = wb_b;

endmodule

// File: hdl/lc4_execute.sv
`timescale 1ns/1ps

module lc4_execute import lc4_pkg::*; (
   input  dec_t   i_dec,
   input  word_t  i_rs_data, // read in decode
   input  word_t  i_rt_data,
   input  trace_t i_wb_a,
   input  trace_t i_wb_b,
   output word_t  o_result,
   output nzp_t   o_nzp
);

   word_t op_a;
   word_t op_b;

   // a producer one pair ahead sits in writeback and has not reached the regfile
   assign op_a = wb_forward(i_dec.r1sel, i_rs_data, i_wb_a, i_wb_b);
   assign op_b = i_dec.use_imm ? i_dec.imm
                               : wb_forward(i_dec.r2sel, i_rt_data, i_wb_a, i_wb_b);

   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD:  o_result = op_a + op_b;
         ALU_SUB:  o_result = op_a - op_b;
         ALU_AND:  o_result = op_a & op_b;
         ALU_OR:   o_result = op_a | op_b;
         ALU_XOR:  o_result = op_a ^ op_b;
         ALU_NOT:  o_result = ~op_a;
         ALU_PASS: o_result = op_b;
         default:  o_result = '0;
      endcase
   end

   // sign first, then zero
   always_comb begin
      if (o_result[$bits(word_t)-1]) begin
         o_nzp = 3'b100;
      end else if (o_result == '0) begin
         o_nzp = 3'b010;
      end else begin
         o_nzp = 3'b001;
      end
   end

endmodule

// File: hdl/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   input  reg_sel_t i_rs_a,
   input  reg_sel_t i_rt_a,
   input  reg_sel_t i_rs_b,
   input  reg_sel_t i_rt_b,
   output word_t    o_rs_data_a,
   output word_t    o_rt_data_a,
   output word_t    o_rs_data_b,
   output word_t    o_rt_data_b,
   input  trace_t   i_wb_a,
   input  trace_t   i_wb_b
);

   word_t regs [`LC4_NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (i_wb_a.regfile_we) begin
            regs[i_wb_a.wsel] <= i_wb_a.rd_data;
         end
         if (i_wb_b.regfile_we) begin
            regs[i_wb_b.wsel] <= i_wb_b.rd_data; // later write wins on a clash
         end
      end
   end

   // write-through so decode sees this cycle's writeback
   assign o_rs_data_a = wb_forward(i_rs_a, regs[i_rs_a], i_wb_a, i_wb_b);
   assign o_rt_data_a = wb_forward(i_rt_a, regs[i_rt_a], i_wb_a, i_wb_b);
   assign o_rs_data_b = wb_forward(i_rs_b, regs[i_rs_b], i_wb_a, i_wb_b);
   assign o_rt_data_b = wb_forward(i_rt_b, regs[i_rt_b], i_wb_a, i_wb_b);

   // result data travels from execute through the trace registers
   a_wdata_known_a : assert property (@(posedge gwe) disable iff (i_reset)
      i_wb_a.regfile_we |-> !$isunknown(i_wb_a.rd_data));
   a_wdata_known_b : assert property (@(posedge gwe) disable iff (i_reset)
      i_wb_b.regfile_we |-> !$isunknown(i_wb_b.rd_data));

endmodule

// File: hdl/lc4_decode.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_decode import lc4_pkg::*; (
   input  word_t i_insn,
   output dec_t  o_dec
);

   opcode_t               opcode;
   logic [`LC4_SUB_W-1:0] sub_op;
   logic                  kept;   // word is in the supported subset

   assign opcode = opcode_t'(i_insn[`LC4_OP_LSB +: `LC4_OP_W]);
   assign sub_op = i_insn[`LC4_SUB_LSB +: `LC4_SUB_W];

   always_comb begin
      o_dec       = '0;
      kept        = 1'b1;
      o_dec.r1sel = i_insn[`LC4_RS_LSB +: `LC4_REG_W];
      o_dec.r2sel = i_insn[`LC4_RT_LSB +: `LC4_REG_W];
      o_dec.wsel  = i_insn[`LC4_RD_LSB +: `LC4_REG_W];
      o_dec.imm   = word_t'($signed(i_insn[`LC4_IMM5_W-1:0]));
      o_dec.r1re  = 1'b1;
      o_dec.r2re  = 1'b1;
      case (opcode)
         OP_ARITH: begin
            case (sub_op) inside
               3'b000:  o_dec.alu_op = ALU_ADD;
               3'b010:  o_dec.alu_op = ALU_SUB;
               3'b1??: begin
                  o_dec.alu_op  = ALU_ADD; // ADDI
                  o_dec.use_imm = 1'b1;
                  o_dec.r2re    = 1'b0;
               end
               default: kept = 1'b0; // MUL and DIV not supported
            endcase
         end
         OP_LOGIC: begin
            case (sub_op)
               3'b000:  o_dec.alu_op = ALU_AND;
               3'b010:  o_dec.alu_op = ALU_OR;
               3'b011:  o_dec.alu_op = ALU_XOR;
               3'b001: begin
                  o_dec.alu_op = ALU_NOT;
                  o_dec.r2re   = 1'b0;
               end
               default: kept = 1'b0; // ANDI falls out here
            endcase
         end
         OP_CONST: begin
            o_dec.alu_op  = ALU_PASS;
            o_dec.use_imm = 1'b1;
            o_dec.imm     = word_t'($signed(i_insn[`LC4_IMM9_W-1:0]));
            o_dec.r1re    = 1'b0;
            o_dec.r2re    = 1'b0;
         end
         default: kept = 1'b0;
      endcase
      if (kept) begin
         o_dec.regfile_we = 1'b1;
      end else begin
         o_dec = '0; // behaves as NOP
      end
   end

endmodule

// File: hdl/lc4_fetch.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_fetch import lc4_pkg::*; (
   input  logic  gwe,
   input  logic  i_reset,
   input  logic  i_split,  // pair in decode has B reading A's destination
   input  word_t i_insn_a, // word at pc
   input  word_t i_insn_b, // word at pc+1
   output word_t o_cur_pc,
   output slot_t o_slot_a,
   output slot_t o_slot_b
);

   word_t        pc_q;
   word_t        pc_inc;
   issue_state_t issue_q;   // HELD while decode holds a reissued pair
   issue_state_t issue_nxt;
   slot_t        slot_a_nxt;
   slot_t        slot_b_nxt;

   function automatic slot_t make_slot(word_t pc, word_t insn);
      slot_t s;
      s.pc    = pc;
      s.insn  = insn;
      s.stall = (insn == '0) ? STALL_EMPTY : STALL_NONE;
      return s;
   endfunction

   assign o_cur_pc  = pc_q;
   assign issue_nxt = i_split ? ISSUE_HELD : ISSUE_PAIR;

   always_comb begin
      case (issue_nxt)
         ISSUE_HELD: begin
            // held B goes out first with the word at pc behind it
            slot_a_nxt = make_slot(o_slot_b.pc, o_slot_b.insn);
            slot_b_nxt = make_slot(pc_q, i_insn_a);
            pc_inc     = word_t'(1);
         end
         default: begin
            slot_a_nxt = make_slot(pc_q, i_insn_a);
            slot_b_nxt = make_slot(pc_q + word_t'(1), i_insn_b);
            pc_inc     = word_t'(2);
         end
      endcase
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q     <= `LC4_RESET_PC;
         issue_q  <= ISSUE_PAIR;
         o_slot_a <= SLOT_EMPTY;
         o_slot_b <= SLOT_EMPTY;
      end else begin
         pc_q     <= pc_q + pc_inc;
         issue_q  <= issue_nxt;
         o_slot_a <= slot_a_nxt;
         o_slot_b <= slot_b_nxt;
      end
   end

   // a reissued pair sits in program order right behind the pc
   a_held_order : assert property (@(posedge gwe) disable iff (i_reset)
      issue_q == ISSUE_HELD |->
         o_slot_b.pc == o_slot_a.pc + word_t'(1) && pc_q == o_slot_b.pc + word_t'(1));

endmodule

// File: hdl/lc4_pkg.sv
`include "lc4_settings.svh"

package lc4_pkg;

   typedef logic [`LC4_WORD_W-1:0] word_t;
   typedef logic [`LC4_REG_W-1:0]  reg_sel_t;
   typedef logic [2:0]             nzp_t;      // n, z, p from the top bit down

   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_PIPE  = 2'd1, // held back by a pair split
      STALL_EMPTY = 2'd2  // reset bubble or NOP
   } stall_t;

   typedef enum logic [3:0] {
      OP_ARITH = 4'b0001, // ADD, SUB, ADDI
      OP_LOGIC = 4'b0101, // AND, NOT, OR, XOR
      OP_CONST = 4'b1001
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_PASS // second operand straight through for CONST
   } alu_op_t;

   typedef enum logic {
      ISSUE_PAIR,
      ISSUE_HELD
   } issue_state_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      stall_t stall;
   } slot_t;

   typedef struct packed {
      reg_sel_t r1sel;
      reg_sel_t r2sel;
      logic     r1re;
      logic     r2re;
      reg_sel_t wsel;
      logic     regfile_we;
      alu_op_t  alu_op;
      logic     use_imm;  // second operand comes from imm
      word_t    imm;      // already sign extended
   } dec_t;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      stall_t   stall;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    rd_data;
      logic     nzp_we;
      nzp_t     nzp_bits;
   } trace_t;

   localparam slot_t SLOT_EMPTY = '{pc: '0, insn: '0, stall: STALL_EMPTY};

   // B is the younger writer of a pair and is looked at first
   function automatic word_t wb_forward(reg_sel_t sel, word_t fallback,
                                        trace_t wb_a, trace_t wb_b);
      if (wb_b.regfile_we && wb_b.wsel == sel) begin
         return wb_b.rd_data;
      end
      if (wb_a.regfile_we && wb_a.wsel == sel) begin
         return wb_a.rd_data;
      end
      return fallback;
   endfunction

endpackage

// File: hdl/lc4_settings.svh
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

`define LC4_WORD_W   16       // data, instruction and pc width
`define LC4_REG_W    3
`define LC4_NUM_REGS 8
`define LC4_RESET_PC 16'h8200 // boot address

// instruction field positions
`define LC4_OP_LSB   12 // opcode in [15:12]
`define LC4_OP_W     4
`define LC4_RD_LSB   9
`define LC4_RS_LSB   6
`define LC4_RT_LSB   0
`define LC4_SUB_LSB  3  // sub-op in [5:3], bit 5 set means imm5 on ADD
`define LC4_SUB_W    3
`define LC4_IMM5_W   5
`define LC4_IMM9_W   9

`endif
